/* neander_dp_settings.svh */
/*
 * Shared parameters for the accumulator CPU datapath
 *   data and address widths
 *   reset values of the program counter and stack pointer
 */
`ifndef NEANDER_DP_SETTINGS_SVH
`define NEANDER_DP_SETTINGS_SVH

// Widths --------------
`define NDP_DATA_W 8      // Data byte
`define NDP_ADDR_W 16     // 64 KB address space

// Reset values --------
`define NDP_PC_RESET 16'h0000   // Execution starts at the bottom of memory
`define NDP_SP_RESET 16'h00FF   // Stack grows down from the top of page 0

`endif

/* neander_dp_pkg.sv */
/*
 * Datapath package
 *   data_t / addr_t word types
 *   ALU operation, address select, index mode,
 *   write-data source and register input enums
 */
`include "neander_dp_settings.svh"

package neander_dp_pkg;

    typedef logic [`NDP_DATA_W-1:0] data_t;   // One data byte
    typedef logic [`NDP_ADDR_W-1:0] addr_t;   // Memory address

    // ALU operations
    typedef enum logic [3:0] {
        ADD, ADC, SUB, AND, OR, XOR, NOT, NEG, SHL, SHR, PASS_B
    } alu_op_e;

    // REM source
    typedef enum logic [1:0] {SEL_RDM, SEL_PC, SEL_SP} addr_sel_e;

    // Effective address index
    typedef enum logic [1:0] {IDX_NONE, IDX_X, IDX_Y, IDX_SP} idx_mode_e;

    // Memory write data
    typedef enum logic [2:0] {SRC_AC, SRC_PC_LO, SRC_PC_HI, SRC_X, SRC_Y} mem_src_e;

    // AC input
    typedef enum logic [1:0] {AC_ALU, AC_MEM, AC_X, AC_Y} ac_src_e;

    // X/Y input
    typedef enum logic {XY_MEM, XY_AC} xy_src_e;

endpackage

/* neander_addr_unit.sv */
/*
 * Address unit
 *   PC with load and increment
 *   SP with increment and decrement
 *   REM with PC/RDM/SP select, RDM built from two bytes
 *   Indexed effective address onto the memory bus
 */
`timescale 1ns/1ps
`include "neander_dp_settings.svh"

module neander_addr_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      pc_inc,
    input  logic                      pc_load,
    input  logic                      sp_inc,
    input  logic                      sp_dec,
    input  logic                      rem_load,
    input  logic                      rdm_load_lo,
    input  logic                      rdm_load_hi,
    input  neander_dp_pkg::addr_sel_e addr_sel,
    input  neander_dp_pkg::idx_mode_e idx_mode,
    input  neander_dp_pkg::data_t     mem_data_in,
    input  neander_dp_pkg::data_t     x,
    input  neander_dp_pkg::data_t     y,
    output neander_dp_pkg::addr_t     mem_addr,
    output neander_dp_pkg::addr_t     pc,
    output neander_dp_pkg::addr_t     sp
);
    import neander_dp_pkg::*;

    localparam int PAD_W = `NDP_ADDR_W - `NDP_DATA_W;

    addr_t rem;        // Address register
    addr_t rdm;        // 16-bit data register, assembled bytewise
    addr_t rem_in;     // Selected REM source
    addr_t x_ext;      // Index values widened to the address
    addr_t y_ext;

    // Program counter --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= `NDP_PC_RESET;
        else if (pc_load)
            pc <= rdm;                  // Jump target from RDM
        else if (pc_inc)
            pc <= pc + addr_t'(1);
    end

    // Stack pointer --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            sp <= `NDP_SP_RESET;
        else if (sp_dec)
            sp <= sp - addr_t'(1);      // Push side, wins over pop
        else if (sp_inc)
            sp <= sp + addr_t'(1);
    end

    // REM source select
    always_comb begin
        case (addr_sel)
            SEL_PC:  rem_in = pc;       // Fetch
            SEL_SP:  rem_in = sp;       // Stack access
            default: rem_in = rdm;      // Operand address
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            rem <= '0;
        else if (rem_load)
            rem <= rem_in;
    end

    // RDM, two independent byte lanes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdm <= '0;
        end else begin
            if (rdm_load_lo)
                rdm[`NDP_DATA_W-1:0] <= mem_data_in;            // First operand byte
            if (rdm_load_hi)
                rdm[`NDP_ADDR_W-1:`NDP_DATA_W] <= mem_data_in;  // Second operand byte
        end
    end

    // Effective address --------------------
    assign x_ext = {{PAD_W{1'b0}}, x};   // Zero extend, carry may reach the high byte
    assign y_ext = {{PAD_W{1'b0}}, y};

    always_comb begin
        case (idx_mode)
            IDX_X:   mem_addr = rem + x_ext;
            IDX_Y:   mem_addr = rem + y_ext;
            IDX_SP:  mem_addr = rem + sp;   // Stack relative
            default: mem_addr = rem;        // Plain REM
        endcase
    end

endmodule

/* neander_alu.sv */
/*
 * Combinational 8-bit ALU
 *   add, add with carry, subtract, negate
 *   bitwise logic, one-bit shifts, B pass-through
 */
`timescale 1ns/1ps

module neander_alu (
    input  neander_dp_pkg::data_t   a,
    input  neander_dp_pkg::data_t   b,
    input  neander_dp_pkg::alu_op_e op,
    input  logic                    carry_in,
    output neander_dp_pkg::data_t   result,
    output logic                    carry_out
);
    import neander_dp_pkg::*;

    always_comb begin
        result    = a;          // Unused codes leave A untouched
        carry_out = 1'b0;       // Logic ops clear the carry
        case (op)
            // Arithmetic, carry is bit 8 of the wide result
            ADD:
                {carry_out, result} = {1'b0, a} + {1'b0, b};
            ADC:
                {carry_out, result} = {1'b0, a} + {1'b0, b} + carry_in;
            SUB:
                {carry_out, result} = {1'b0, a} - {1'b0, b};   // Carry set on borrow
            NEG:
                {carry_out, result} = -{1'b0, a};              // Borrow unless A is zero

            // Bitwise logic
            AND:
                result = a & b;
            OR:
                result = a | b;
            XOR:
                result = a ^ b;
            NOT:
                result = ~a;

            // Shifts, the bit shifted out lands in carry
            SHL:
                {carry_out, result} = {a, 1'b0};
            SHR:
                {result, carry_out} = {1'b0, a};

            PASS_B:
                result = b;     // Memory operand or constant straight through

            default: begin
                result    = a;
                carry_out = 1'b0;
            end
        endcase
    end

endmodule

/* neander_acc_regs.sv */
/*
 * Accumulator and index registers
 *   AC input select from ALU, memory, X or Y
 *   X and Y with load, increment and decrement
 *   N/Z/C flags with separate NZ and C loads
 */
`timescale 1ns/1ps
`include "neander_dp_settings.svh"

module neander_acc_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ac_load,
    input  logic                    nz_load,
    input  logic                    c_load,
    input  logic                    x_load,
    input  logic                    x_inc,
    input  logic                    x_dec,
    input  logic                    y_load,
    input  logic                    y_inc,
    input  logic                    y_dec,
    input  neander_dp_pkg::ac_src_e ac_src,
    input  neander_dp_pkg::xy_src_e xy_src,
    input  neander_dp_pkg::data_t   mem_data_in,
    input  neander_dp_pkg::data_t   alu_result,
    input  logic                    alu_carry,
    output neander_dp_pkg::data_t   ac,
    output neander_dp_pkg::data_t   x,
    output neander_dp_pkg::data_t   y,
    output logic                    flag_n,
    output logic                    flag_z,
    output logic                    flag_c
);
    import neander_dp_pkg::*;

    data_t      ac_in;        // Selected AC input
    data_t      xy_in;        // Shared X/Y input
    data_t      idx_q [2];    // Index registers, 0 is X and 1 is Y
    logic [1:0] idx_load;
    logic [1:0] idx_inc;
    logic [1:0] idx_dec;

    // Input selects --------------------
    always_comb begin
        case (ac_src)
            AC_MEM:  ac_in = mem_data_in;   // Load from memory
            AC_X:    ac_in = x;             // Transfer from X
            AC_Y:    ac_in = y;             // Transfer from Y
            default: ac_in = alu_result;
        endcase
    end

    assign xy_in = (xy_src == XY_AC) ? ac : mem_data_in;

    // Accumulator --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            ac <= '0;
        else if (ac_load)
            ac <= ac_in;
    end

    // Index registers --------------------
    assign idx_load = {y_load, x_load};
    assign idx_inc  = {y_inc, x_inc};
    assign idx_dec  = {y_dec, x_dec};

    // Same update for X and Y, load over inc over dec
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2; i++)
                idx_q[i] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (idx_load[i])
                    idx_q[i] <= xy_in;
                else if (idx_inc[i])
                    idx_q[i] <= idx_q[i] + data_t'(1);    // Wraps at FF
                else if (idx_dec[i])
                    idx_q[i] <= idx_q[i] - data_t'(1);    // Wraps at 00
            end
        end
    end

    assign x = idx_q[0];
    assign y = idx_q[1];

    // Flags --------------------
    // N and Z look at the AC input, so loads and transfers set them too
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flag_n <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end else begin
            if (nz_load) begin
                flag_n <= ac_in[`NDP_DATA_W-1];   // Sign bit
                flag_z <= (ac_in == '0);
            end
            if (c_load)
                flag_c <= alu_carry;              // Only arithmetic and shifts load C
        end
    end

endmodule

/* neander_dp.sv */
/*
 * Datapath top level
 *   address unit, ALU and register file wiring
 *   ALU B operand select, memory write-data select
 *   debug views of PC, SP, AC, X and Y
 */
`timescale 1ns/1ps
`include "neander_dp_settings.svh"

module neander_dp (
    input  logic                      clk,
    input  logic                      reset,
    // Control unit
    input  logic                      pc_inc,
    input  logic                      pc_load,
    input  logic                      sp_inc,
    input  logic                      sp_dec,
    input  logic                      rem_load,
    input  neander_dp_pkg::addr_sel_e addr_sel,
    input  logic                      rdm_load_lo,
    input  logic                      rdm_load_hi,
    input  neander_dp_pkg::idx_mode_e idx_mode,
    input  neander_dp_pkg::alu_op_e   alu_op,
    input  logic                      alu_b_const,
    input  logic                      ac_load,
    input  neander_dp_pkg::ac_src_e   ac_src,
    input  logic                      nz_load,
    input  logic                      c_load,
    input  logic                      x_load,
    input  logic                      x_inc,
    input  logic                      x_dec,
    input  logic                      y_load,
    input  logic                      y_inc,
    input  logic                      y_dec,
    input  neander_dp_pkg::xy_src_e   xy_src,
    input  neander_dp_pkg::mem_src_e  mem_src,
    // Memory
    input  neander_dp_pkg::data_t     mem_data_in,
    output neander_dp_pkg::addr_t     mem_addr,
    output neander_dp_pkg::data_t     mem_data_out,
    // Status and debug
    output logic                      flag_n,
    output logic                      flag_z,
    output logic                      flag_c,
    output neander_dp_pkg::addr_t     dbg_pc,
    output neander_dp_pkg::addr_t     dbg_sp,
    output neander_dp_pkg::data_t     dbg_ac,
    output neander_dp_pkg::data_t     dbg_x,
    output neander_dp_pkg::data_t     dbg_y
);
    import neander_dp_pkg::*;

    addr_t pc, sp;
    data_t ac, x, y;
    data_t alu_b;           // ALU B operand
    data_t alu_result;
    logic  alu_carry;

    // Units --------------------
    neander_addr_unit u_addr (
        .clk(clk), .reset(reset),
        .pc_inc(pc_inc), .pc_load(pc_load),
        .sp_inc(sp_inc), .sp_dec(sp_dec),
        .rem_load(rem_load), .rdm_load_lo(rdm_load_lo), .rdm_load_hi(rdm_load_hi),
        .addr_sel(addr_sel), .idx_mode(idx_mode),
        .mem_data_in(mem_data_in), .x(x), .y(y),
        .mem_addr(mem_addr), .pc(pc), .sp(sp)
    );

    assign alu_b = alu_b_const ? data_t'(1) : mem_data_in;   // Constant 1 for INC/DEC

    neander_alu u_alu (
        .a(ac), .b(alu_b), .op(alu_op), .carry_in(flag_c),
        .result(alu_result), .carry_out(alu_carry)
    );

    neander_acc_regs u_regs (
        .clk(clk), .reset(reset),
        .ac_load(ac_load), .nz_load(nz_load), .c_load(c_load),
        .x_load(x_load), .x_inc(x_inc), .x_dec(x_dec),
        .y_load(y_load), .y_inc(y_inc), .y_dec(y_dec),
        .ac_src(ac_src), .xy_src(xy_src),
        .mem_data_in(mem_data_in), .alu_result(alu_result), .alu_carry(alu_carry),
        .ac(ac), .x(x), .y(y),
        .flag_n(flag_n), .flag_z(flag_z), .flag_c(flag_c)
    );

    // Write data --------------------
    always_comb begin
        case (mem_src)
            SRC_PC_LO: mem_data_out = pc[`NDP_DATA_W-1:0];              // Return address low
            SRC_PC_HI: mem_data_out = pc[`NDP_ADDR_W-1:`NDP_DATA_W];    // Return address high
            SRC_X:     mem_data_out = x;
            SRC_Y:     mem_data_out = y;
            default:   mem_data_out = ac;                               // Store and push
        endcase
    end

    // Debug views
    assign dbg_pc = pc;
    assign dbg_sp = sp;
    assign dbg_ac = ac;
    assign dbg_x  = x;
    assign dbg_y  = y;

endmodule

/* neander_dp_asserts.sv */
/*
 * Concurrent assertions bound into the datapath top
 *   SP priority when push and pop meet
 *   PC jump target from RDM, SP value out of reset
 */
`timescale 1ns/1ps
`include "neander_dp_settings.svh"

module neander_dp_asserts (
    input logic                  clk,
    input logic                  reset,
    input logic                  pc_load,
    input logic                  sp_inc,
    input logic                  sp_dec,
    input neander_dp_pkg::addr_t pc,
    input neander_dp_pkg::addr_t sp,
    input neander_dp_pkg::addr_t rdm
);
    import neander_dp_pkg::*;

    // Push and pop together, the decrement must win
    sp_dec_wins: assert property (@(posedge clk) disable iff (reset)
        (sp_inc && sp_dec) |=> (sp == $past(sp) - addr_t'(1)))
        else $error("SP did not decrement with sp_inc and sp_dec both set");

    // Jump lands on the assembled RDM
    pc_from_rdm: assert property (@(posedge clk) disable iff (reset)
        pc_load |=> (pc == $past(rdm)))
        else $error("PC does not hold the RDM value after pc_load");

    sp_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (sp == `NDP_SP_RESET))
        else $error("SP is not at its reset value after reset");

endmodule

bind neander_dp neander_dp_asserts u_asserts (
    .clk(clk), .reset(reset), .pc_load(pc_load), .sp_inc(sp_inc), .sp_dec(sp_dec),
    .pc(dbg_pc), .sp(dbg_sp), .rdm(u_addr.rdm)
);

/* neander_dp_tb.sv */
/*
 * Testbench for the accumulator CPU datapath
 *   reads control lines and expected values from the golden file
 *   drives each line as the control unit would, one per clock
 *   compares memory bus, flags and register views every cycle
 */
`timescale 1ns/1ps
`include "neander_dp_settings.svh"

module neander_dp_tb;
    import neander_dp_pkg::*;

    localparam int N_COLS       = 35;   // 25 driven fields, 10 expected
    localparam int MAX_ROWS     = 64;
    localparam int RESET_CYCLES = 4;

    logic      clk, reset;
    logic      pc_inc, pc_load, sp_inc, sp_dec, rem_load, rdm_load_lo, rdm_load_hi;
    logic      alu_b_const, ac_load, nz_load, c_load;
    logic      x_load, x_inc, x_dec, y_load, y_inc, y_dec;
    addr_sel_e addr_sel;
    idx_mode_e idx_mode;
    alu_op_e   alu_op;
    ac_src_e   ac_src;
    xy_src_e   xy_src;
    mem_src_e  mem_src;
    data_t     mem_data_in, mem_data_out, dbg_ac, dbg_x, dbg_y;
    addr_t     mem_addr, dbg_pc, dbg_sp;
    logic      flag_n, flag_z, flag_c;

    int golden [MAX_ROWS][N_COLS];     // One row per cycle
    int tok [N_COLS];                  // Fields of the line being parsed
    int n_rows      = 0;
    int cycle_count = 0;
    int cycle_limit = 0;               // Zero until the golden file is read

    neander_dp uut (
        .clk(clk), .reset(reset),
        .pc_inc(pc_inc), .pc_load(pc_load), .sp_inc(sp_inc), .sp_dec(sp_dec),
        .rem_load(rem_load), .addr_sel(addr_sel),
        .rdm_load_lo(rdm_load_lo), .rdm_load_hi(rdm_load_hi), .idx_mode(idx_mode),
        .alu_op(alu_op), .alu_b_const(alu_b_const), .ac_load(ac_load), .ac_src(ac_src),
        .nz_load(nz_load), .c_load(c_load),
        .x_load(x_load), .x_inc(x_inc), .x_dec(x_dec),
        .y_load(y_load), .y_inc(y_inc), .y_dec(y_dec),
        .xy_src(xy_src), .mem_src(mem_src),
        .mem_data_in(mem_data_in), .mem_addr(mem_addr), .mem_data_out(mem_data_out),
        .flag_n(flag_n), .flag_z(flag_z), .flag_c(flag_c),
        .dbg_pc(dbg_pc), .dbg_sp(dbg_sp), .dbg_ac(dbg_ac), .dbg_x(dbg_x), .dbg_y(dbg_y)
    );

    always #5 clk = ~clk;              // 10 ns period

    // Reporting --------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "datapath run stopped");
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp)
            fail_run($sformatf("** Error at %0d ns: %s expected %h, actual %h",
                               $time, name, exp, act));
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp)
            fail_run($sformatf("** Error at %0d ns: %s expected %h, actual %h",
                               $time, name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("** Error at %0d ns: %s expected %b, actual %b",
                               $time, name, exp, act));
    endtask

    // Golden file --------------------
    // Splits one text line into hex fields
    task automatic split_line(input string s, output int count);
        string t;
        byte   c;
        count = 0;
        t     = "";
        for (int i = 0; i <= s.len(); i++) begin
            c = (i < s.len()) ? s[i] : 8'h20;     // Trailing blank flushes the last token
            if (c == " " || c == "\n" || c == "\r" || c == "\t") begin
                if (t.len() > 0) begin
                    if (count < N_COLS)
                        tok[count] = t.atohex();
                    count++;
                    t = "";
                end
            end else begin
                t = {t, string'(c)};
            end
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    count;
        string line;
        fd = $fopen("neander_dp_golden.txt", "r");
        if (fd == 0)
            fail_run("Could not open the golden file neander_dp_golden.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#")
                continue;                          // Column notes and blank lines
            split_line(line, count);
            if (count == 0)
                continue;
            if (count != N_COLS)
                fail_run($sformatf("Golden line %0d has %0d fields instead of %0d",
                                   n_rows + 1, count, N_COLS));
            if (n_rows >= MAX_ROWS)
                fail_run("The golden file has more lines than the testbench can hold");
            for (int k = 0; k < N_COLS; k++)
                golden[n_rows][k] = tok[k];
            n_rows++;
        end
        $fclose(fd);
    endtask

    // Drive and compare --------------------
    task automatic apply_row(input int r);
        pc_inc      = golden[r][0][0];
        pc_load     = golden[r][1][0];
        sp_inc      = golden[r][2][0];
        sp_dec      = golden[r][3][0];
        rem_load    = golden[r][4][0];
        addr_sel    = addr_sel_e'(golden[r][5][1:0]);
        rdm_load_lo = golden[r][6][0];
        rdm_load_hi = golden[r][7][0];
        idx_mode    = idx_mode_e'(golden[r][8][1:0]);
        alu_op      = alu_op_e'(golden[r][9][3:0]);
        alu_b_const = golden[r][10][0];
        ac_load     = golden[r][11][0];
        ac_src      = ac_src_e'(golden[r][12][1:0]);
        nz_load     = golden[r][13][0];
        c_load      = golden[r][14][0];
        x_load      = golden[r][15][0];
        x_inc       = golden[r][16][0];
        x_dec       = golden[r][17][0];
        y_load      = golden[r][18][0];
        y_inc       = golden[r][19][0];
        y_dec       = golden[r][20][0];
        xy_src      = xy_src_e'(golden[r][21][0]);
        mem_src     = mem_src_e'(golden[r][22][2:0]);
        if (golden[r][23][0])
            mem_data_in = data_t'($urandom);       // Bus value unused this cycle
        else
            mem_data_in = data_t'(golden[r][24]);
    endtask

    // State visible during the cycle before the next edge
    task automatic check_row(input int r);
        check_addr("mem_addr", addr_t'(golden[r][25]), mem_addr);
        check_data("mem_data_out", data_t'(golden[r][26]), mem_data_out);
        check_flag("flag_n", golden[r][27][0], flag_n);
        check_flag("flag_z", golden[r][28][0], flag_z);
        check_flag("flag_c", golden[r][29][0], flag_c);
        check_addr("dbg_pc", addr_t'(golden[r][30]), dbg_pc);
        check_addr("dbg_sp", addr_t'(golden[r][31]), dbg_sp);
        check_data("dbg_ac", data_t'(golden[r][32]), dbg_ac);
        check_data("dbg_x", data_t'(golden[r][33]), dbg_x);
        check_data("dbg_y", data_t'(golden[r][34]), dbg_y);
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit)
            fail_run("Timeout, the run went past its cycle limit");
    end

    // Main sequence --------------------
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        pc_inc      = 1'b0;
        pc_load     = 1'b0;
        sp_inc      = 1'b0;
        sp_dec      = 1'b0;
        rem_load    = 1'b0;
        addr_sel    = SEL_RDM;
        rdm_load_lo = 1'b0;
        rdm_load_hi = 1'b0;
        idx_mode    = IDX_NONE;
        alu_op      = ADD;
        alu_b_const = 1'b0;
        ac_load     = 1'b0;
        ac_src      = AC_ALU;
        nz_load     = 1'b0;
        c_load      = 1'b0;
        x_load      = 1'b0;
        x_inc       = 1'b0;
        x_dec       = 1'b0;
        y_load      = 1'b0;
        y_inc       = 1'b0;
        y_dec       = 1'b0;
        xy_src      = XY_MEM;
        mem_src     = SRC_AC;
        mem_data_in = '0;
        void'($urandom(64999));                   // Single seed for the run

        load_golden();
        if (n_rows == 0)
            fail_run("The golden file holds no test lines");
        cycle_limit = RESET_CYCLES + n_rows + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);                          // 1 ns after the edge
            #8;
            check_row(r);                          // 1 ns before the next edge
            @(posedge clk);
            #1;
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* neander_dp_golden.txt */
# pi pl si sd rl as rlo rhi idx op bc al acs nz cl xl xi xd yl yi yd xys ms rnd mem_in |
# then expected: mem_addr mem_out n z c pc sp ac x y  (all hex, rnd=1 means random mem_in)
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 0000 00 0 0 0 0000 00FF 00 00 00
1 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 0000 00 0 0 0 0000 00FF 00 00 00
1 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 0000 00 0 0 0 0001 00FF 00 00 00
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 0001 00 0 0 0 0002 00FF 00 00 00
1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 34 0001 00 0 0 0 0002 00FF 00 00 00
0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 12 0001 00 0 0 0 0003 00FF 00 00 00
1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 0001 00 0 0 0 0003 00FF 00 00 00
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 00 0001 34 0 0 0 1234 00FF 00 00 00
0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 1 00 0001 12 0 0 0 1234 00FF 00 00 00
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 1234 00 0 0 0 1234 00FF 00 00 00
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 F0 1234 00 0 0 0 1234 00FF 00 00 00
0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 1 0 0 0 3 0 05 1324 F0 0 0 0 1234 00FF 00 F0 00
0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 4 1 00 1239 05 0 0 0 1234 00FF 00 F0 05
0 0 0 0 0 0 0 0 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 1333 00 0 0 0 1234 00FF 00 F0 05
0 0 0 0 0 0 0 0 0 0 0 1 1 1 0 0 0 0 0 0 0 0 0 0 C8 1234 00 0 0 0 1234 00FF 00 F0 05
0 0 0 0 0 0 0 0 0 0 0 1 0 1 1 0 0 0 0 0 0 0 0 0 50 1234 C8 1 0 0 1234 00FF C8 F0 05
0 0 0 0 0 0 0 0 0 1 0 1 0 1 1 0 0 0 0 0 0 0 0 0 01 1234 18 0 0 1 1234 00FF 18 F0 05
0 0 0 0 0 0 0 0 0 2 0 1 0 1 1 0 0 0 0 0 0 0 0 0 20 1234 1A 0 0 0 1234 00FF 1A F0 05
0 0 0 0 0 0 0 0 0 3 0 1 0 1 1 0 0 0 0 0 0 0 0 0 0F 1234 FA 1 0 1 1234 00FF FA F0 05
0 0 0 0 0 0 0 0 0 4 0 1 0 1 0 0 0 0 0 0 0 0 0 0 F0 1234 0A 0 0 0 1234 00FF 0A F0 05
0 0 0 0 0 0 0 0 0 5 0 1 0 1 0 0 0 0 0 0 0 0 0 0 FA 1234 FA 1 0 0 1234 00FF FA F0 05
0 0 0 0 0 0 0 0 0 6 0 1 0 1 0 0 0 0 0 0 0 0 0 1 00 1234 00 0 1 0 1234 00FF 00 F0 05
0 0 0 0 0 0 0 0 0 8 0 1 0 1 1 0 0 0 0 0 0 0 0 1 00 1234 FF 1 0 0 1234 00FF FF F0 05
0 0 0 0 0 0 0 0 0 9 0 1 0 1 1 0 0 0 0 0 0 0 0 1 00 1234 FE 1 0 1 1234 00FF FE F0 05
0 0 0 0 0 0 0 0 0 0 1 1 0 1 1 0 0 0 0 0 0 0 0 1 00 1234 7F 0 0 0 1234 00FF 7F F0 05
0 0 0 0 0 0 0 0 0 8 0 1 0 1 0 0 0 0 0 0 0 0 0 1 00 1234 80 1 0 0 1234 00FF 80 F0 05
0 0 0 0 0 0 0 0 0 0 0 1 2 1 0 0 0 0 0 0 0 0 0 1 00 1234 00 0 1 0 1234 00FF 00 F0 05
0 0 0 0 0 0 0 0 0 0 0 1 3 1 0 0 0 0 0 0 0 0 0 1 00 1234 F0 1 0 0 1234 00FF F0 F0 05
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 1 0 1 00 1234 05 0 0 0 1234 00FF 05 F0 05
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0 0 0 0 0 FF 1234 05 0 0 0 1234 00FF 05 05 05
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0 0 3 1 00 1234 FF 0 0 0 1234 00FF 05 FF FF
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0 4 1 00 1234 00 0 0 0 1234 00FF 05 00 00
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 0 1 1 1 0 1 00 1234 05 0 0 0 1234 00FF 05 FF FF
0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 1234 05 0 0 0 1234 00FF 05 05 00
0 0 0 1 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 1234 05 0 0 0 1234 00FE 05 05 00
0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 00FE 05 0 0 0 1234 00FD 05 05 00
0 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 00FE 05 0 0 0 1234 00FE 05 05 00
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 00FE 05 0 0 0 1234 00FD 05 05 00

/* neander_dp.f */
+incdir+.
neander_dp_pkg.sv
neander_addr_unit.sv
neander_alu.sv
neander_acc_regs.sv
neander_dp.sv
neander_dp_asserts.sv
neander_dp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the datapath testbench with Verilator and run it.
# The simulator's exit status is the test result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f neander_dp.f \
    --top-module neander_dp_tb \
    -o neander_dp_sim

./obj_dir/neander_dp_sim
